// ==== piano_pkg.sv ====
package piano_pkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------
    localparam int NUM_KEYS = 12;
    localparam int NOTE_W   = 4;
    // Round and note counters limit the song to 16 notes
    localparam int ROUND_W  = 4;

    // Defaults for the top level
    localparam int SONG_LEN_DEF       = 16;
    localparam int SHOW_CYCLES_DEF    = 50;
    localparam int TIMEOUT_CYCLES_DEF = 400;

    // ----------------------------------------------------------------------
    // Types
    // ----------------------------------------------------------------------
    typedef logic [NOTE_W-1:0] note_t;

    typedef enum logic {
        MODE_GENIUS = 1'b0,
        MODE_FREE   = 1'b1
    } mode_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_MENU,
        ST_INIT,
        ST_ROUND_START,
        ST_SHOW,
        ST_SHOW_GAP,
        ST_PLAYER_START,
        ST_WAIT_KEY,
        ST_PLAY_KEY,
        ST_COMPARE,
        ST_NEXT_NOTE,
        ST_NEXT_ROUND,
        ST_WON,
        ST_LOST,
        ST_FREE
    } game_state_t;

endpackage

// ==== seq_if.sv ====
`timescale 1ns/1ps

interface seq_if;

    // Strobes from the controller
    logic             clear_round;
    logic             next_round;
    logic             clear_note;
    logic             next_note;
    logic             capture_key;

    // Datapath status
    piano_pkg::note_t song_note;
    logic             last_note;
    logic             last_round;
    logic             key_match;

    modport ctrl (
        output clear_round, next_round, clear_note, next_note, capture_key,
        input  song_note, last_note, last_round, key_match
    );

    modport dp (
        input  clear_round, next_round, clear_note, next_note, capture_key,
        output song_note, last_note, last_round, key_match
    );

endinterface

// ==== timer_if.sv ====
`timescale 1ns/1ps

interface timer_if;

    // Four-phase display handshake
    logic show_req;
    logic show_ack;

    // Player timeout
    logic wait_enable;
    logic timeout;

    modport ctrl (
        output show_req, wait_enable,
        input  show_ack, timeout
    );

    modport tmr (
        input  show_req, wait_enable,
        output show_ack, timeout
    );

endinterface

// ==== key_input.sv ====
`timescale 1ns/1ps

module key_input (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          start,
    input  logic                          enter,
    input  logic [piano_pkg::NUM_KEYS-1:0] keys,
    output logic                          start_pulse,
    output logic                          enter_pulse,
    output logic                          key_press,
    output logic                          key_down,
    output piano_pkg::note_t              key_note
);

    localparam int NK   = piano_pkg::NUM_KEYS;
    localparam int IN_W = NK + 2;

    logic [IN_W-1:0] sync_1;
    logic [IN_W-1:0] sync_2;
    logic            start_s;
    logic            enter_s;
    logic [NK-1:0]   keys_s;
    logic            start_q;
    logic            enter_q;
    logic            any_down;

    // Lowest index wins when several keys are held
    function automatic piano_pkg::note_t lowest_key(input logic [NK-1:0] k);
        piano_pkg::note_t idx;
        idx = '0;
        for (int i = NK - 1; i >= 0; i--) begin
            if (k[i]) begin
                idx = piano_pkg::note_t'(i);
            end
        end
        return idx;
    endfunction

    assign {start_s, enter_s, keys_s} = sync_2;
    assign any_down = |keys_s;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            sync_1      <= '0;
            sync_2      <= '0;
            start_q     <= 1'b0;
            enter_q     <= 1'b0;
            start_pulse <= 1'b0;
            enter_pulse <= 1'b0;
            key_down    <= 1'b0;
            key_press   <= 1'b0;
        end else begin
            sync_1      <= {start, enter, keys};
            sync_2      <= sync_1;
            start_q     <= start_s;
            enter_q     <= enter_s;
            start_pulse <= start_s & ~start_q;
            enter_pulse <= enter_s & ~enter_q;
            key_down    <= any_down;
            key_press   <= any_down & ~key_down;
        end
    end

    // Held until the next press
    always_ff @(posedge clock) begin
        if (any_down && !key_down) begin
            key_note <= lowest_key(keys_s);
        end
    end

endmodule

// ==== note_timer.sv ====
`timescale 1ns/1ps

module note_timer #(
    parameter int SHOW_CYCLES    = piano_pkg::SHOW_CYCLES_DEF,
    parameter int TIMEOUT_CYCLES = piano_pkg::TIMEOUT_CYCLES_DEF
) (
    input  logic clock,
    input  logic reset,
    timer_if.tmr tmr
);

    localparam int SHOW_W = $clog2(SHOW_CYCLES);
    localparam int WAIT_W = $clog2(TIMEOUT_CYCLES);

    logic [SHOW_W-1:0] show_cnt;
    logic [WAIT_W-1:0] wait_cnt;
    logic              wait_done;

    // ----------------------------------------------------------------------
    // Display handshake
    // ----------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            show_cnt     <= '0;
            tmr.show_ack <= 1'b0;
        end else if (!tmr.show_req) begin
            show_cnt     <= '0;
            tmr.show_ack <= 1'b0;
        end else if (!tmr.show_ack) begin
            show_cnt <= show_cnt + 1'b1;
            // Ack is up on the last cycle of the note
            if (show_cnt == SHOW_W'(SHOW_CYCLES - 2)) begin
                tmr.show_ack <= 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Player timeout
    // ----------------------------------------------------------------------
    assign wait_done = (wait_cnt == WAIT_W'(TIMEOUT_CYCLES - 1));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (!tmr.wait_enable) begin
            wait_cnt <= '0;
        end else if (!wait_done) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    assign tmr.timeout = tmr.wait_enable & wait_done;

endmodule

// ==== sequence_datapath.sv ====
`timescale 1ns/1ps

module sequence_datapath #(
    parameter int SONG_LEN = piano_pkg::SONG_LEN_DEF
) (
    input  logic             clock,
    input  logic             reset,
    input  piano_pkg::note_t key_note,
    seq_if.dp                seq
);

    localparam int RW        = piano_pkg::ROUND_W;
    localparam int ROM_DEPTH = 2 ** RW;

    piano_pkg::note_t song_rom [ROM_DEPTH];
    logic [RW-1:0]    round;
    logic [RW-1:0]    note_addr;
    piano_pkg::note_t captured;

    initial begin
        $readmemh("song.mem", song_rom);
    end

    // ----------------------------------------------------------------------
    // Round and note counters
    // ----------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            round <= '0;
        end else if (seq.clear_round) begin
            round <= '0;
        end else if (seq.next_round) begin
            round <= round + 1'b1;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            note_addr <= '0;
        end else if (seq.clear_note) begin
            note_addr <= '0;
        end else if (seq.next_note) begin
            note_addr <= note_addr + 1'b1;
        end
    end

    // Key the player released last
    always_ff @(posedge clock) begin
        if (seq.capture_key) begin
            captured <= key_note;
        end
    end

    // ----------------------------------------------------------------------
    // Status
    // ----------------------------------------------------------------------
    assign seq.song_note  = song_rom[note_addr];
    assign seq.last_note  = (note_addr == round);
    assign seq.last_round = (round == RW'(SONG_LEN - 1));
    assign seq.key_match  = (captured == seq.song_note);

endmodule

// ==== game_controller.sv ====
`timescale 1ns/1ps

module game_controller (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           start_pulse,
    input  logic                           enter_pulse,
    input  logic                           key_press,
    input  logic                           key_down,
    input  piano_pkg::note_t               key_note,
    input  logic                           mode_free,
    seq_if.ctrl                            seq,
    timer_if.ctrl                          tmr,
    output logic [piano_pkg::NUM_KEYS-1:0] leds,
    output logic                           play,
    output logic                           from_song,
    output logic                           player_turn,
    output logic                           menu_active,
    output logic                           won,
    output logic                           lost
);

    piano_pkg::game_state_t state;
    piano_pkg::game_state_t state_next;
    piano_pkg::mode_t       mode;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= piano_pkg::ST_IDLE;
            mode  <= piano_pkg::MODE_GENIUS;
        end else begin
            state <= state_next;
            if (state == piano_pkg::ST_MENU && enter_pulse) begin
                mode <= mode_free ? piano_pkg::MODE_FREE : piano_pkg::MODE_GENIUS;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Next state
    // ----------------------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            piano_pkg::ST_IDLE: if (start_pulse) state_next = piano_pkg::ST_MENU;
            piano_pkg::ST_MENU: if (enter_pulse) state_next = piano_pkg::ST_INIT;
            piano_pkg::ST_INIT: state_next = (mode == piano_pkg::MODE_FREE) ?
                                             piano_pkg::ST_FREE : piano_pkg::ST_ROUND_START;
            piano_pkg::ST_ROUND_START: state_next = piano_pkg::ST_SHOW;
            piano_pkg::ST_SHOW: if (tmr.show_ack) state_next = piano_pkg::ST_SHOW_GAP;
            // Old ack must be gone before the next request
            piano_pkg::ST_SHOW_GAP: begin
                if (!tmr.show_ack) begin
                    state_next = seq.last_note ? piano_pkg::ST_PLAYER_START
                                               : piano_pkg::ST_NEXT_NOTE;
                end
            end
            piano_pkg::ST_NEXT_NOTE: state_next = piano_pkg::ST_SHOW;
            piano_pkg::ST_PLAYER_START: state_next = piano_pkg::ST_WAIT_KEY;
            piano_pkg::ST_WAIT_KEY: begin
                if (tmr.timeout) begin
                    state_next = piano_pkg::ST_LOST;
                end else if (key_press) begin
                    state_next = piano_pkg::ST_PLAY_KEY;
                end
            end
            piano_pkg::ST_PLAY_KEY: if (!key_down) state_next = piano_pkg::ST_COMPARE;
            piano_pkg::ST_COMPARE: begin
                if (!seq.key_match) begin
                    state_next = piano_pkg::ST_LOST;
                end else if (!seq.last_note) begin
                    state_next = piano_pkg::ST_WAIT_KEY;
                end else begin
                    state_next = seq.last_round ? piano_pkg::ST_WON : piano_pkg::ST_NEXT_ROUND;
                end
            end
            piano_pkg::ST_NEXT_ROUND: state_next = piano_pkg::ST_ROUND_START;
            piano_pkg::ST_WON, piano_pkg::ST_LOST: begin
                if (start_pulse) state_next = piano_pkg::ST_MENU;
            end
            piano_pkg::ST_FREE: if (enter_pulse) state_next = piano_pkg::ST_MENU;
            default: state_next = piano_pkg::ST_IDLE;
        endcase
    end

    // ----------------------------------------------------------------------
    // Moore outputs
    // ----------------------------------------------------------------------
    assign seq.clear_round = (state == piano_pkg::ST_INIT);
    assign seq.clear_note  = (state == piano_pkg::ST_ROUND_START) ||
                             (state == piano_pkg::ST_PLAYER_START);
    // Compare also steps the note address
    assign seq.next_note   = (state == piano_pkg::ST_NEXT_NOTE) ||
                             (state == piano_pkg::ST_COMPARE);
    assign seq.next_round  = (state == piano_pkg::ST_NEXT_ROUND);
    assign seq.capture_key = (state == piano_pkg::ST_PLAY_KEY);

    assign tmr.show_req    = (state == piano_pkg::ST_SHOW);
    assign tmr.wait_enable = (state == piano_pkg::ST_WAIT_KEY);

    assign from_song   = (state == piano_pkg::ST_SHOW);
    assign play        = (state == piano_pkg::ST_SHOW) || (state == piano_pkg::ST_PLAY_KEY) ||
                         (state == piano_pkg::ST_FREE && key_down);
    assign player_turn = (state == piano_pkg::ST_WAIT_KEY);
    assign menu_active = (state == piano_pkg::ST_MENU);
    assign won         = (state == piano_pkg::ST_WON);
    assign lost        = (state == piano_pkg::ST_LOST);

    always_comb begin
        leds = '0;
        case (state)
            piano_pkg::ST_SHOW:     leds[seq.song_note] = 1'b1;
            piano_pkg::ST_PLAY_KEY: leds[key_note] = 1'b1;
            piano_pkg::ST_FREE:     if (key_down) leds[key_note] = 1'b1;
            default:                leds = '0;
        endcase
    end

endmodule

// ==== piano_top.sv ====
`timescale 1ns/1ps

module piano_top #(
    parameter int SONG_LEN       = piano_pkg::SONG_LEN_DEF,
    parameter int SHOW_CYCLES    = piano_pkg::SHOW_CYCLES_DEF,
    parameter int TIMEOUT_CYCLES = piano_pkg::TIMEOUT_CYCLES_DEF
) (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           start,
    input  logic                           enter,
    input  logic                           mode_free,
    input  logic [piano_pkg::NUM_KEYS-1:0] keys,
    output logic [piano_pkg::NUM_KEYS-1:0] leds,
    output logic                           play,
    output logic                           from_song,
    output logic                           player_turn,
    output logic                           menu_active,
    output logic                           won,
    output logic                           lost
);

    logic             start_pulse;
    logic             enter_pulse;
    logic             key_press;
    logic             key_down;
    piano_pkg::note_t key_note;

    seq_if   seq_bus ();
    timer_if tmr_bus ();

    key_input i_key_input (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .enter       (enter),
        .keys        (keys),
        .start_pulse (start_pulse),
        .enter_pulse (enter_pulse),
        .key_press   (key_press),
        .key_down    (key_down),
        .key_note    (key_note)
    );

    game_controller i_game_controller (
        .clock       (clock),
        .reset       (reset),
        .start_pulse (start_pulse),
        .enter_pulse (enter_pulse),
        .key_press   (key_press),
        .key_down    (key_down),
        .key_note    (key_note),
        .mode_free   (mode_free),
        .seq         (seq_bus.ctrl),
        .tmr         (tmr_bus.ctrl),
        .leds        (leds),
        .play        (play),
        .from_song   (from_song),
        .player_turn (player_turn),
        .menu_active (menu_active),
        .won         (won),
        .lost        (lost)
    );

    sequence_datapath #(
        .SONG_LEN (SONG_LEN)
    ) i_sequence_datapath (
        .clock    (clock),
        .reset    (reset),
        .key_note (key_note),
        .seq      (seq_bus.dp)
    );

    note_timer #(
        .SHOW_CYCLES    (SHOW_CYCLES),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) i_note_timer (
        .clock (clock),
        .reset (reset),
        .tmr   (tmr_bus.tmr)
    );

endmodule

// ==== piano_checker.sv ====
`timescale 1ns/1ps

module piano_checker #(
    parameter int SHOW_CYCLES = 8
) (
    input  logic        clock,
    input  logic [11:0] leds,
    input  logic        play,
    input  logic        from_song,
    input  logic        player_turn,
    input  logic [63:0] song_flat,
    output int          total_errors
);

    int   test_errors  = 0;
    int   passed_tests = 0;
    int   failed_tests = 0;
    int   shown        = 0;
    int   round_no     = 0;
    int   run_len      = 0;
    logic player_seen  = 1'b0;
    logic from_song_q  = 1'b0;
    logic player_q     = 1'b0;

    initial begin
        total_errors = 0;
    end

    task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s is 'h%0h, expected 'h%0h", $time, what, got, exp);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic count_failure();
        test_errors++;
        total_errors++;
    endtask

    // ------------------------------------------------------------------
    // Song display with one run of from_song per note
    // ------------------------------------------------------------------
    always @(negedge clock) begin
        if (from_song && !from_song_q && player_seen) begin
            // New round restarts from the first note
            shown = 0;
            round_no++;
            player_seen = 1'b0;
        end
        if (from_song && !from_song_q) begin
            run_len = 0;
        end
        if (from_song) begin
            expect_eq("shown note leds", leds, 32'd1 << song_flat[shown*4 +: 4]);
            expect_eq("play during shown note", play, 1);
            run_len++;
        end
        if (!from_song && from_song_q) begin
            expect_eq("note display cycles", run_len, SHOW_CYCLES);
            shown++;
        end
        if (player_turn && !player_q && !player_seen) begin
            expect_eq("notes shown in round", shown, round_no + 1);
            player_seen = 1'b1;
        end
        from_song_q = from_song;
        player_q    = player_turn;
    end

    task automatic begin_test();
        test_errors = 0;
        shown       = 0;
        round_no    = 0;
        player_seen = 1'b0;
    endtask

    task automatic expect_round(input int exp);
        expect_eq("last round shown", round_no, exp);
    endtask

    task automatic end_test(input int id, input string name);
        if (test_errors == 0) begin
            passed_tests++;
            $display("test %0d %s: passed", id, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed with %0d errors", id, name, test_errors);
        end
    endtask

    task automatic report_counts();
        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 passed_tests + failed_tests, passed_tests, failed_tests, total_errors);
    endtask

endmodule

// ==== tb_piano.sv ====
`timescale 1ns/1ps

module tb_piano;

    localparam int SONG_LEN       = 4;
    localparam int SHOW_CYCLES    = 8;
    localparam int TIMEOUT_CYCLES = 60;
    localparam int NUM_TESTS      = 8;

    typedef enum logic [1:0] {FAULT_NONE, FAULT_WRONG, FAULT_TIMEOUT} fault_t;
    typedef enum logic [1:0] {RES_NONE, RES_WON, RES_LOST} result_t;
    typedef enum logic [1:0] {SIG_MENU, SIG_TURN, SIG_PLAY, SIG_END} probe_t;

    typedef struct packed {
        logic    free_mode;
        int      rounds;
        fault_t  fault;
        int      key;
        result_t result;
    } test_row_t;

    logic        clock;
    logic        reset;
    logic        start;
    logic        enter;
    logic        mode_free;
    logic [11:0] keys;
    logic [11:0] leds;
    logic        play;
    logic        from_song;
    logic        player_turn;
    logic        menu_active;
    logic        won;
    logic        lost;
    logic [3:0]  song_mem [16];
    logic [63:0] song_flat;
    test_row_t   rows [NUM_TESTS];
    int          row_count = 0;
    int          total_errors;
    int          seed;
    int          rnd;

    piano_top #(
        .SONG_LEN       (SONG_LEN),
        .SHOW_CYCLES    (SHOW_CYCLES),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) i_piano_top (
        .clock (clock), .reset (reset), .start (start), .enter (enter),
        .mode_free (mode_free), .keys (keys), .leds (leds), .play (play),
        .from_song (from_song), .player_turn (player_turn),
        .menu_active (menu_active), .won (won), .lost (lost)
    );

    piano_checker #(
        .SHOW_CYCLES (SHOW_CYCLES)
    ) i_checker (
        .clock (clock), .leds (leds), .play (play), .from_song (from_song),
        .player_turn (player_turn), .song_flat (song_flat), .total_errors (total_errors)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic logic probe(input probe_t which);
        case (which)
            SIG_MENU: return menu_active;
            SIG_TURN: return player_turn;
            SIG_PLAY: return play;
            default:  return won | lost;
        endcase
    endfunction

    function automatic string row_name(input test_row_t row);
        if (row.free_mode) return $sformatf("free mode key %0d", row.key);
        if (row.fault == FAULT_WRONG) return $sformatf("wrong key in round %0d", row.rounds);
        if (row.fault == FAULT_TIMEOUT) return $sformatf("timeout in round %0d", row.rounds);
        return "genius mode won";
    endfunction

    task automatic add_row(input logic free_mode, input int rounds, input fault_t fault,
                           input int key, input result_t result);
        rows[row_count].free_mode = free_mode;
        rows[row_count].rounds    = rounds;
        rows[row_count].fault     = fault;
        rows[row_count].key       = key;
        rows[row_count].result    = result;
        row_count++;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s did not happen in time, the DUT looks stuck", what);
        i_checker.count_failure();
    endtask

    task automatic wait_until(input probe_t which, input logic level, input int limit,
                              input string what);
        int n;
        n = 0;
        @(negedge clock);
        while (probe(which) !== level && n < limit) begin
            @(negedge clock);
            n++;
        end
        if (probe(which) !== level) report_timeout(what);
    endtask

    task automatic press_button(input logic is_start);
        int hold;
        hold = 2 + $urandom % 3;
        @(posedge clock);
        if (is_start) start <= 1'b1;
        else enter <= 1'b1;
        repeat (hold) @(posedge clock);
        start <= 1'b0;
        enter <= 1'b0;
    endtask

    // ------------------------------------------------------------------
    // Player actions
    // ------------------------------------------------------------------
    task automatic play_key(input int k);
        int hold;
        hold = 1 + $urandom % 4;
        wait_until(SIG_TURN, 1'b1, 600, "player turn");
        @(posedge clock);
        keys <= 12'd1 << k;
        wait_until(SIG_TURN, 1'b0, 20, "key accepted");
        i_checker.expect_eq("played key leds", leds, 32'd1 << k);
        i_checker.expect_eq("play while key held", play, 1);
        repeat (hold) @(posedge clock);
        keys <= '0;
    endtask

    task automatic sit_out_turn();
        int n;
        n = 0;
        wait_until(SIG_TURN, 1'b1, 600, "player turn");
        while (player_turn && n < TIMEOUT_CYCLES + 10) begin
            @(negedge clock);
            n++;
        end
        i_checker.expect_eq("player turn cycles before timeout", n, TIMEOUT_CYCLES);
    endtask

    task automatic run_genius(input test_row_t row);
        int   r;
        int   n;
        logic ended;
        r = 0;
        ended = 1'b0;
        while (r < SONG_LEN && !ended) begin
            n = 0;
            while (n <= r && !ended) begin
                if (r == row.rounds && row.fault == FAULT_TIMEOUT) begin
                    sit_out_turn();
                    ended = 1'b1;
                end else if (r == row.rounds && row.fault == FAULT_WRONG && n == r) begin
                    play_key((song_mem[n] + 1 + $urandom % 11) % 12);
                    ended = 1'b1;
                end else begin
                    play_key(song_mem[n]);
                end
                n++;
            end
            r++;
        end
        wait_until(SIG_END, 1'b1, 100, "game result");
        i_checker.expect_round(row.rounds < SONG_LEN ? row.rounds : SONG_LEN - 1);
    endtask

    task automatic run_free(input int k);
        int hold;
        hold = 3 + $urandom % 6;
        @(posedge clock);
        keys <= 12'd1 << k;
        wait_until(SIG_PLAY, 1'b1, 20, "free mode note");
        repeat (hold) begin
            i_checker.expect_eq("free mode leds", leds, 32'd1 << k);
            i_checker.expect_eq("free mode play", play, 1);
            i_checker.expect_eq("won or lost in free mode", won | lost, 0);
            @(negedge clock);
        end
        @(posedge clock);
        keys <= '0;
        wait_until(SIG_PLAY, 1'b0, 20, "free mode release");
        i_checker.expect_eq("free mode leds after release", leds, 0);
        press_button(1'b0);
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        reset     = 1'b1;
        start     = 1'b0;
        enter     = 1'b0;
        mode_free = 1'b0;
        keys      = '0;
        seed      = 32'h84e;
        rnd       = $urandom(seed);
        $readmemh("song.mem", song_mem);
        for (int i = 0; i < 16; i++) begin
            song_flat[i*4 +: 4] = song_mem[i];
        end
        add_row(1'b0, 4, FAULT_NONE, 0, RES_WON);
        add_row(1'b0, 1, FAULT_WRONG, 0, RES_LOST);
        add_row(1'b1, 0, FAULT_NONE, 5, RES_NONE);
        add_row(1'b0, 2, FAULT_TIMEOUT, 0, RES_LOST);
        add_row(1'b0, 0, FAULT_WRONG, 0, RES_LOST);
        add_row(1'b1, 0, FAULT_NONE, 0, RES_NONE);
        add_row(1'b0, 3, FAULT_TIMEOUT, 0, RES_LOST);
        add_row(1'b1, 0, FAULT_NONE, 11, RES_NONE);

        repeat (10) @(posedge clock);
        reset <= 1'b0;
        i_checker.begin_test();
        repeat (4) begin
            @(negedge clock);
            i_checker.expect_eq("outputs before start",
                {leds, play, from_song, player_turn, menu_active, won, lost}, 0);
        end
        press_button(1'b1);
        wait_until(SIG_MENU, 1'b1, 20, "menu after start");
        i_checker.end_test(0, "reset and start");

        for (int i = 0; i < NUM_TESTS; i++) begin
            i_checker.begin_test();
            repeat (1 + $urandom % 4) begin
                @(negedge clock);
                i_checker.expect_eq("menu active before enter", menu_active, 1);
            end
            @(posedge clock);
            mode_free <= rows[i].free_mode;
            press_button(1'b0);
            wait_until(SIG_MENU, 1'b0, 20, "menu exit on enter");
            if (rows[i].free_mode) begin
                run_free(rows[i].key);
            end else begin
                run_genius(rows[i]);
                // Result must hold until start
                repeat (2) begin
                    i_checker.expect_eq("won", won, rows[i].result == RES_WON);
                    i_checker.expect_eq("lost", lost, rows[i].result == RES_LOST);
                    repeat (1 + $urandom % 5) @(negedge clock);
                end
                press_button(1'b1);
            end
            wait_until(SIG_MENU, 1'b1, 20, "menu return");
            i_checker.end_test(i + 1, row_name(rows[i]));
        end

        i_checker.report_counts();
        if (total_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== song.mem ====
// Song note index per line in hex, 0 is C and b is B
4
4
5
7
7
5
4
2
0
0
2
4
4
2
2
0

// ==== files.f ====
piano_pkg.sv
seq_if.sv
timer_if.sv
key_input.sv
note_timer.sv
sequence_datapath.sv
game_controller.sv
piano_top.sv
piano_checker.sv
tb_piano.sv
